// File: logic/issue_pkg.sv
`default_nettype none

package issue_pkg;

    // Datapath and tag widths
    localparam int XLEN = 32;
    localparam int TAG_W = 3;

    // Entries per reservation table
    localparam int TABLE_DEPTH = 4;

    // Multiplier pipeline depth
    localparam int MUL_STAGES = 3;

    // Operation code carried by the dispatch strobe
    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_SLL   = 4'h5,
        OP_SRL   = 4'h6,
        OP_SLT   = 4'h7,
        OP_MUL   = 4'h8,
        OP_MULH  = 4'h9,
        OP_MULHU = 4'ha
    } op_code_e;

    // Payload of the ALU table
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // Payload of the multiply table
    typedef enum logic [1:0] {
        MUL_LO    = 2'd0,
        MUL_HI_SS = 2'd1,
        MUL_HI_UU = 2'd2
    } mul_op_e;

endpackage

`default_nettype wire

// File: logic/dispatch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_decode
    import issue_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             disp_valid,
    input  op_code_e         disp_op,
    input  logic [TAG_W-1:0] disp_tag,
    input  logic             src1_ready,
    input  logic [TAG_W-1:0] src1_tag,
    input  logic [XLEN-1:0]  src1_value,
    input  logic             src2_ready,
    input  logic [TAG_W-1:0] src2_tag,
    input  logic [XLEN-1:0]  src2_value,
    input  logic             cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  logic [XLEN-1:0]  cdb_value,
    input  logic             alu_full,
    input  logic             mul_full,
    output logic             alu_write,
    output logic             mul_write,
    output alu_op_e          alu_op,
    output mul_op_e          mul_op,
    output logic [TAG_W-1:0] entry_tag,
    output logic             op1_ready,
    output logic [TAG_W-1:0] op1_tag,
    output logic [XLEN-1:0]  op1_value,
    output logic             op2_ready,
    output logic [TAG_W-1:0] op2_tag,
    output logic [XLEN-1:0]  op2_value
);

    logic legal;
    logic is_mul;
    logic fwd1;
    logic fwd2;

    // Table select and payload
    always_comb begin
        legal  = 1'b1;
        is_mul = 1'b0;
        alu_op = ALU_ADD;
        mul_op = MUL_LO;
        case (disp_op)
            OP_ADD:   alu_op = ALU_ADD;
            OP_SUB:   alu_op = ALU_SUB;
            OP_AND:   alu_op = ALU_AND;
            OP_OR:    alu_op = ALU_OR;
            OP_XOR:   alu_op = ALU_XOR;
            OP_SLL:   alu_op = ALU_SLL;
            OP_SRL:   alu_op = ALU_SRL;
            OP_SLT:   alu_op = ALU_SLT;
            OP_MUL: begin
                is_mul = 1'b1;
                mul_op = MUL_LO;
            end
            OP_MULH: begin
                is_mul = 1'b1;
                mul_op = MUL_HI_SS;
            end
            OP_MULHU: begin
                is_mul = 1'b1;
                mul_op = MUL_HI_UU;
            end
            default:  legal = 1'b0;
        endcase
    end

    assign alu_write = disp_valid && legal && !is_mul;
    assign mul_write = disp_valid && legal && is_mul;
    assign entry_tag = disp_tag;

    // A result on the bus this cycle would be missed by the table, so catch it here
    assign fwd1 = !src1_ready && cdb_valid && (src1_tag == cdb_tag);
    assign fwd2 = !src2_ready && cdb_valid && (src2_tag == cdb_tag);

    assign op1_ready = src1_ready || fwd1;
    assign op1_tag   = src1_tag;
    assign op1_value = fwd1 ? cdb_value : src1_value;
    assign op2_ready = src2_ready || fwd2;
    assign op2_tag   = src2_tag;
    assign op2_value = fwd2 ? cdb_value : src2_value;

    a_legal_op: assert property (@(posedge clk) disable iff (rst)
        disp_valid |-> legal);

    // Source has to honour dispatch_stall for the table it addresses
    a_no_dispatch_full: assert property (@(posedge clk) disable iff (rst)
        (alu_write |-> !alu_full) and (mul_write |-> !mul_full));

endmodule

`default_nettype wire

// File: logic/reservation_table.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_table
    import issue_pkg::*;
#(
    parameter type payload_t = alu_op_e
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             write,
    input  payload_t         payload_in,
    input  logic [TAG_W-1:0] tag_in,
    input  logic             op1_ready,
    input  logic [TAG_W-1:0] op1_tag,
    input  logic [XLEN-1:0]  op1_value,
    input  logic             op2_ready,
    input  logic [TAG_W-1:0] op2_tag,
    input  logic [XLEN-1:0]  op2_value,
    input  logic             cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  logic [XLEN-1:0]  cdb_value,
    input  logic             issue_enable,
    output logic             full,
    output logic             issue_valid,
    output payload_t         issue_payload,
    output logic [TAG_W-1:0] issue_tag,
    output logic [XLEN-1:0]  issue_a,
    output logic [XLEN-1:0]  issue_b
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    logic [TABLE_DEPTH-1:0] busy;
    logic [TABLE_DEPTH-1:0] s1_rdy;
    logic [TABLE_DEPTH-1:0] s2_rdy;
    payload_t               payload [TABLE_DEPTH];
    logic [TAG_W-1:0]       tag     [TABLE_DEPTH];
    logic [TAG_W-1:0]       s1_tag  [TABLE_DEPTH];
    logic [TAG_W-1:0]       s2_tag  [TABLE_DEPTH];
    logic [XLEN-1:0]        s1_val  [TABLE_DEPTH];
    logic [XLEN-1:0]        s2_val  [TABLE_DEPTH];

    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] sel_idx;
    logic             have_ready;
    logic             do_issue;

    assign full = &busy;

    // Lowest free slot and lowest ready entry from registered state
    always_comb begin
        free_idx   = '0;
        sel_idx    = '0;
        have_ready = 1'b0;
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = IDX_W'(i);
            end
            if (busy[i] && s1_rdy[i] && s2_rdy[i]) begin
                sel_idx    = IDX_W'(i);
                have_ready = 1'b1;
            end
        end
    end

    assign do_issue = issue_enable && have_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= do_issue;
            if (do_issue) begin
                busy[sel_idx] <= 1'b0;
            end
            // A write never lands on the slot just issued, which was busy
            if (write) begin
                busy[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // Wakeup from the bus
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (cdb_valid && busy[i] && !s1_rdy[i] && s1_tag[i] == cdb_tag) begin
                s1_rdy[i] <= 1'b1;
                s1_val[i] <= cdb_value;
            end
            if (cdb_valid && busy[i] && !s2_rdy[i] && s2_tag[i] == cdb_tag) begin
                s2_rdy[i] <= 1'b1;
                s2_val[i] <= cdb_value;
            end
        end
        if (write) begin
            payload[free_idx] <= payload_in;
            tag[free_idx]     <= tag_in;
            s1_rdy[free_idx]  <= op1_ready;
            s1_tag[free_idx]  <= op1_tag;
            s1_val[free_idx]  <= op1_value;
            s2_rdy[free_idx]  <= op2_ready;
            s2_tag[free_idx]  <= op2_tag;
            s2_val[free_idx]  <= op2_value;
        end
        // Issue register
        if (do_issue) begin
            issue_payload <= payload[sel_idx];
            issue_tag     <= tag[sel_idx];
            issue_a       <= s1_val[sel_idx];
            issue_b       <= s2_val[sel_idx];
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        write |-> !full);

endmodule

`default_nettype wire

// File: logic/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import issue_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  alu_op_e          op,
    input  logic [TAG_W-1:0] tag,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    output logic             done,
    output logic [TAG_W-1:0] done_tag,
    output logic [XLEN-1:0]  done_value
);

    logic [XLEN-1:0] result;
    logic [4:0]      shamt;

    assign shamt = b[4:0];

    always_comb begin
        result = '0;
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            // Signed compare
            ALU_SLT: result = XLEN'($signed(a) < $signed(b));
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            done_tag   <= tag;
            done_value <= result;
        end
    end

endmodule

`default_nettype wire

// File: logic/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import issue_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  mul_op_e          op,
    input  logic [TAG_W-1:0] tag,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    output logic             done,
    output logic [TAG_W-1:0] done_tag,
    output logic [XLEN-1:0]  done_value,
    output logic             slot_next
);

    // Index 0 is stage 1
    logic [MUL_STAGES-1:0] stage_valid;
    logic [TAG_W-1:0]      stage_tag [MUL_STAGES];
    // Last stage needs no op, the half is already picked
    mul_op_e               stage_op  [MUL_STAGES-1];

    logic signed [XLEN:0]  a_ext;
    logic signed [XLEN:0]  b_ext;
    logic [2*XLEN-1:0]     product;
    logic [XLEN-1:0]       result_q;
    logic                  zext;

    assign zext = (op == MUL_HI_UU);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= {stage_valid[MUL_STAGES-2:0], start};
        end
    end

    always_ff @(posedge clk) begin
        stage_tag[0] <= tag;
        stage_op[0]  <= op;
        for (int s = 1; s < MUL_STAGES; s++) begin
            stage_tag[s] <= stage_tag[s-1];
        end
        for (int s = 1; s < MUL_STAGES - 1; s++) begin
            stage_op[s] <= stage_op[s-1];
        end
        // Stage 1, one extra bit so MULHU shares the signed multiplier
        a_ext <= {zext ? 1'b0 : a[XLEN-1], a};
        b_ext <= {zext ? 1'b0 : b[XLEN-1], b};
        // Stage 2
        product <= a_ext * b_ext;
        // Stage 3
        result_q <= (stage_op[MUL_STAGES-2] == MUL_LO) ? product[XLEN-1:0]
                                                       : product[2*XLEN-1:XLEN];
    end

    assign done       = stage_valid[MUL_STAGES-1];
    assign done_tag   = stage_tag[MUL_STAGES-1];
    assign done_value = result_q;
    assign slot_next  = stage_valid[0];

endmodule

`default_nettype wire

// File: logic/writeback_bus.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_bus
    import issue_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             alu_done,
    input  logic [TAG_W-1:0] alu_tag,
    input  logic [XLEN-1:0]  alu_value,
    input  logic             mul_done,
    input  logic [TAG_W-1:0] mul_tag,
    input  logic [XLEN-1:0]  mul_value,
    input  logic             mul_slot_next,
    output logic             alu_grant,
    output logic             cdb_valid,
    output logic [TAG_W-1:0] cdb_tag,
    output logic [XLEN-1:0]  cdb_value
);

    // A multiply in stage 1 finishes in the same cycle as an ALU op issued now
    assign alu_grant = !mul_slot_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= alu_done || mul_done;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_done) begin
            cdb_tag   <= mul_tag;
            cdb_value <= mul_value;
        end else if (alu_done) begin
            cdb_tag   <= alu_tag;
            cdb_value <= alu_value;
        end
    end

    // Slot reservation has to keep the two units apart
    a_one_done: assert property (@(posedge clk) disable iff (rst)
        !(alu_done && mul_done));

endmodule

`default_nettype wire

// File: logic/issue_core.sv
`timescale 1ns/1ps
`default_nettype none

module issue_core
    import issue_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             disp_valid,
    input  op_code_e         disp_op,
    input  logic [TAG_W-1:0] disp_tag,
    input  logic             src1_ready,
    input  logic [TAG_W-1:0] src1_tag,
    input  logic [XLEN-1:0]  src1_value,
    input  logic             src2_ready,
    input  logic [TAG_W-1:0] src2_tag,
    input  logic [XLEN-1:0]  src2_value,
    output logic             dispatch_stall,
    output logic             cdb_valid,
    output logic [TAG_W-1:0] cdb_tag,
    output logic [XLEN-1:0]  cdb_value
);

    // Decode to tables
    logic             alu_write;
    logic             mul_write;
    alu_op_e          dec_alu_op;
    mul_op_e          dec_mul_op;
    logic [TAG_W-1:0] entry_tag;
    logic             op1_ready;
    logic [TAG_W-1:0] op1_tag;
    logic [XLEN-1:0]  op1_value;
    logic             op2_ready;
    logic [TAG_W-1:0] op2_tag;
    logic [XLEN-1:0]  op2_value;
    logic             alu_full;
    logic             mul_full;

    // Tables to execute units
    logic             alu_issue;
    alu_op_e          alu_issue_op;
    logic [TAG_W-1:0] alu_issue_tag;
    logic [XLEN-1:0]  alu_a;
    logic [XLEN-1:0]  alu_b;
    logic             mul_issue;
    mul_op_e          mul_issue_op;
    logic [TAG_W-1:0] mul_issue_tag;
    logic [XLEN-1:0]  mul_a;
    logic [XLEN-1:0]  mul_b;

    // Execute units to the bus
    logic             alu_grant;
    logic             alu_done;
    logic [TAG_W-1:0] alu_done_tag;
    logic [XLEN-1:0]  alu_done_value;
    logic             mul_done;
    logic [TAG_W-1:0] mul_done_tag;
    logic [XLEN-1:0]  mul_done_value;
    logic             mul_slot_next;

    assign dispatch_stall = alu_full || mul_full;

    dispatch_decode decode_i (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_op    (disp_op),
        .disp_tag   (disp_tag),
        .src1_ready (src1_ready),
        .src1_tag   (src1_tag),
        .src1_value (src1_value),
        .src2_ready (src2_ready),
        .src2_tag   (src2_tag),
        .src2_value (src2_value),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value),
        .alu_full   (alu_full),
        .mul_full   (mul_full),
        .alu_write  (alu_write),
        .mul_write  (mul_write),
        .alu_op     (dec_alu_op),
        .mul_op     (dec_mul_op),
        .entry_tag  (entry_tag),
        .op1_ready  (op1_ready),
        .op1_tag    (op1_tag),
        .op1_value  (op1_value),
        .op2_ready  (op2_ready),
        .op2_tag    (op2_tag),
        .op2_value  (op2_value)
    );

    reservation_table #(.payload_t(alu_op_e)) alu_table_i (
        .clk           (clk),
        .rst           (rst),
        .write         (alu_write),
        .payload_in    (dec_alu_op),
        .tag_in        (entry_tag),
        .op1_ready     (op1_ready),
        .op1_tag       (op1_tag),
        .op1_value     (op1_value),
        .op2_ready     (op2_ready),
        .op2_tag       (op2_tag),
        .op2_value     (op2_value),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .issue_enable  (alu_grant),
        .full          (alu_full),
        .issue_valid   (alu_issue),
        .issue_payload (alu_issue_op),
        .issue_tag     (alu_issue_tag),
        .issue_a       (alu_a),
        .issue_b       (alu_b)
    );

    // Multiplier is fully pipelined, so this table always issues
    reservation_table #(.payload_t(mul_op_e)) mul_table_i (
        .clk           (clk),
        .rst           (rst),
        .write         (mul_write),
        .payload_in    (dec_mul_op),
        .tag_in        (entry_tag),
        .op1_ready     (op1_ready),
        .op1_tag       (op1_tag),
        .op1_value     (op1_value),
        .op2_ready     (op2_ready),
        .op2_tag       (op2_tag),
        .op2_value     (op2_value),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .issue_enable  (1'b1),
        .full          (mul_full),
        .issue_valid   (mul_issue),
        .issue_payload (mul_issue_op),
        .issue_tag     (mul_issue_tag),
        .issue_a       (mul_a),
        .issue_b       (mul_b)
    );

    alu_unit alu_i (
        .clk        (clk),
        .rst        (rst),
        .start      (alu_issue),
        .op         (alu_issue_op),
        .tag        (alu_issue_tag),
        .a          (alu_a),
        .b          (alu_b),
        .done       (alu_done),
        .done_tag   (alu_done_tag),
        .done_value (alu_done_value)
    );

    mul_unit mul_i (
        .clk        (clk),
        .rst        (rst),
        .start      (mul_issue),
        .op         (mul_issue_op),
        .tag        (mul_issue_tag),
        .a          (mul_a),
        .b          (mul_b),
        .done       (mul_done),
        .done_tag   (mul_done_tag),
        .done_value (mul_done_value),
        .slot_next  (mul_slot_next)
    );

    writeback_bus wb_i (
        .clk           (clk),
        .rst           (rst),
        .alu_done      (alu_done),
        .alu_tag       (alu_done_tag),
        .alu_value     (alu_done_value),
        .mul_done      (mul_done),
        .mul_tag       (mul_done_tag),
        .mul_value     (mul_done_value),
        .mul_slot_next (mul_slot_next),
        .alu_grant     (alu_grant),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value)
    );

endmodule

`default_nettype wire

// File: dv/issue_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_core_tb
    import issue_pkg::*;
();

    localparam int NUM_TAGS = 1 << TAG_W;
    localparam int WAIT_LIMIT = 400;
    localparam int RANDOM_OPS = 40;
    localparam int FILL_PHASE = 3;
    localparam int RANDOM_PHASE = 5;

    // A source that is not ready carries its producer tag in v1 or v2
    typedef struct packed {
        logic [2:0]       phase;
        op_code_e         op;
        logic [TAG_W-1:0] tag;
        logic             r1;
        logic [XLEN-1:0]  v1;
        logic             r2;
        logic [XLEN-1:0]  v2;
    } row_t;

    logic             clk;
    logic             rst;
    logic             disp_valid;
    op_code_e         disp_op;
    logic [TAG_W-1:0] disp_tag;
    logic             src1_ready;
    logic [TAG_W-1:0] src1_tag;
    logic [XLEN-1:0]  src1_value;
    logic             src2_ready;
    logic [TAG_W-1:0] src2_tag;
    logic [XLEN-1:0]  src2_value;
    logic             dispatch_stall;
    logic             cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    logic [XLEN-1:0]  cdb_value;

    row_t            rows [$];
    logic [XLEN-1:0] exp_val [NUM_TAGS] = '{default: '0};
    int              tag_phase [NUM_TAGS] = '{default: 0};
    int              disp_cnt [NUM_TAGS] = '{default: 0};
    int              seen_cnt [NUM_TAGS] = '{default: 0};
    int              stall_cnt = 0;

    issue_core dut_i (
        .clk            (clk),
        .rst            (rst),
        .disp_valid     (disp_valid),
        .disp_op        (disp_op),
        .disp_tag       (disp_tag),
        .src1_ready     (src1_ready),
        .src1_tag       (src1_tag),
        .src1_value     (src1_value),
        .src2_ready     (src2_ready),
        .src2_tag       (src2_tag),
        .src2_value     (src2_value),
        .dispatch_stall (dispatch_stall),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    function automatic string phase_name(input int phase);
        case (phase)
            0:       return "alu_independent";
            1:       return "multiply";
            2:       return "dependency_chain";
            3:       return "alu_table_full";
            4:       return "mixed_traffic";
            default: return "random";
        endcase
    endfunction

    // Reference results from the ISA rules
    function automatic logic [XLEN-1:0] expected_result(input op_code_e op,
                                                         input logic [XLEN-1:0] a,
                                                         input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0]        wide;
        logic signed [2*XLEN-1:0] swide;
        wide  = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        swide = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLL:   return a << b[4:0];
            OP_SRL:   return a >> b[4:0];
            OP_SLT:   return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
            OP_MUL:   return wide[XLEN-1:0];
            OP_MULH:  return swide[2*XLEN-1:XLEN];
            OP_MULHU: return wide[2*XLEN-1:XLEN];
            default:  return '0;
        endcase
    endfunction

    function automatic bit is_pending(input logic [TAG_W-1:0] t);
        return disp_cnt[t] != seen_cnt[t];
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (disp_cnt[t] != seen_cnt[t]) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic void add_row(input int phase, input op_code_e op, input int tag,
                                    input bit r1, input logic [XLEN-1:0] v1,
                                    input bit r2, input logic [XLEN-1:0] v2);
        row_t row;
        row.phase = 3'(phase);
        row.op    = op;
        row.tag   = TAG_W'(tag);
        row.r1    = r1;
        row.v1    = v1;
        row.r2    = r2;
        row.v2    = v2;
        rows.push_back(row);
    endfunction

    function automatic void build_table();
        add_row(0, OP_ADD,   0, 1, 32'h7fffffff, 1, 32'h00000001);
        add_row(0, OP_SUB,   1, 1, 32'h00000005, 1, 32'h0000000a);
        add_row(0, OP_AND,   2, 1, 32'hf0f0f0f0, 1, 32'h3c3c3c3c);
        add_row(0, OP_OR,    3, 1, 32'h12340000, 1, 32'h00005678);
        add_row(0, OP_XOR,   4, 1, 32'hffff0000, 1, 32'h0ff00ff0);
        add_row(0, OP_SLL,   5, 1, 32'h80000001, 1, 32'h00000024);
        add_row(0, OP_SRL,   6, 1, 32'hfffffff0, 1, 32'hffffffe4);
        add_row(0, OP_SLT,   7, 1, 32'hfffffffe, 1, 32'h00000001);
        add_row(0, OP_SLT,   0, 1, 32'h80000000, 1, 32'hffffffff);
        add_row(0, OP_SLT,   1, 1, 32'hfffffffd, 1, 32'hfffffff0);
        // Back to back so several multiplies are in flight
        add_row(1, OP_MUL,   0, 1, 32'hffffffff, 1, 32'hffffffff);
        add_row(1, OP_MULH,  1, 1, 32'h80000000, 1, 32'h80000000);
        add_row(1, OP_MULHU, 2, 1, 32'hffffffff, 1, 32'hffffffff);
        add_row(1, OP_MULH,  3, 1, 32'hffffffff, 1, 32'h00000002);
        add_row(1, OP_MUL,   4, 1, 32'h12345678, 1, 32'h9abcdef0);
        add_row(1, OP_MULHU, 5, 1, 32'h80000000, 1, 32'h00000002);
        add_row(2, OP_ADD,   0, 1, 32'h40000000, 1, 32'h00001234);
        add_row(2, OP_SUB,   1, 0, 0,            1, 32'h00000002);
        add_row(2, OP_MUL,   2, 0, 1,            1, 32'h00000003);
        add_row(2, OP_ADD,   3, 0, 2,            0, 0);
        // Sampled while tag 0 is on the bus, so the decode forwards it
        add_row(2, OP_OR,    6, 0, 0,            1, 32'h00000100);
        add_row(2, OP_MULHU, 4, 0, 3,            0, 2);
        add_row(2, OP_XOR,   5, 0, 4,            0, 1);
        // Slow multiply chain and then ALU ops that wait on its end
        add_row(3, OP_MUL,   0, 1, 32'h00010001, 1, 32'h00000003);
        add_row(3, OP_MUL,   1, 0, 0,            1, 32'h00000005);
        add_row(3, OP_MUL,   2, 0, 1,            1, 32'h00000007);
        add_row(3, OP_ADD,   3, 0, 2,            1, 32'h00000001);
        add_row(3, OP_SUB,   4, 0, 2,            1, 32'h00000001);
        add_row(3, OP_OR,    5, 0, 2,            1, 32'h00000100);
        add_row(3, OP_SLL,   6, 0, 2,            1, 32'h00000002);
        add_row(3, OP_XOR,   7, 0, 2,            0, 3);
        add_row(4, OP_ADD,   0, 1, 32'h00000001, 1, 32'h00000002);
        add_row(4, OP_MUL,   1, 1, 32'h00000003, 1, 32'h00000004);
        add_row(4, OP_SUB,   2, 1, 32'h00000064, 0, 0);
        add_row(4, OP_MULHU, 3, 1, 32'hdeadbeef, 0, 1);
        add_row(4, OP_AND,   4, 0, 2,            1, 32'h000000ff);
        add_row(4, OP_MUL,   5, 0, 0,            0, 2);
        add_row(4, OP_SLT,   6, 0, 5,            0, 3);
        add_row(4, OP_OR,    7, 0, 4,            1, 32'h00001000);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic tick_or_timeout(inout int waited, input string what);
        next_cycle();
        waited++;
        if (waited > WAIT_LIMIT) begin
            report_failure({"Timeout waiting for ", what});
        end
    endtask

    task automatic dispatch_one(input int phase, input op_code_e op,
                                input logic [TAG_W-1:0] tag,
                                input bit r1, input logic [XLEN-1:0] v1,
                                input bit r2, input logic [XLEN-1:0] v2);
        int              waited;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        waited = 0;
        while (is_pending(tag)) begin
            tick_or_timeout(waited, $sformatf("tag %0d to be written back", tag));
        end
        waited = 0;
        while (dispatch_stall) begin
            tick_or_timeout(waited, "dispatch_stall to drop");
        end
        // Producer results come from the model, whether or not they are on the bus yet
        a = r1 ? v1 : exp_val[v1[TAG_W-1:0]];
        b = r2 ? v2 : exp_val[v2[TAG_W-1:0]];
        disp_op    = op;
        disp_tag   = tag;
        src1_ready = r1 || !is_pending(v1[TAG_W-1:0]);
        src1_tag   = v1[TAG_W-1:0];
        src1_value = src1_ready ? a : 32'hdeadbeef;
        src2_ready = r2 || !is_pending(v2[TAG_W-1:0]);
        src2_tag   = v2[TAG_W-1:0];
        src2_value = src2_ready ? b : 32'hdeadbeef;
        exp_val[tag]   = expected_result(op, a, b);
        tag_phase[tag] = phase;
        disp_cnt[tag]  = disp_cnt[tag] + 1;
        disp_valid = 1'b1;
        next_cycle();
        disp_valid = 1'b0;
    endtask

    task automatic finish_phase(input int phase, input int stall_mark);
        int waited;
        waited = 0;
        while (pending_count() != 0) begin
            tick_or_timeout(waited, {"outstanding results in ", phase_name(phase)});
        end
        if (phase == FILL_PHASE) begin
            assert (stall_cnt > stall_mark) else begin
                report_failure("dispatch_stall never went high while the ALU table filled");
            end
        end
    endtask

    // Scoreboard sampled mid-cycle where the bus is stable
    always @(negedge clk) begin
        if (!rst && cdb_valid === 1'b1) begin
            assert (disp_cnt[cdb_tag] == seen_cnt[cdb_tag] + 1) else begin
                report_failure($sformatf("Broadcast of tag %0d which was not outstanding",
                                         cdb_tag));
            end
            assert (cdb_value === exp_val[cdb_tag]) else begin
                report_failure($sformatf("FAILED %s tag %0d expected %08h actual %08h",
                                         phase_name(tag_phase[cdb_tag]), cdb_tag,
                                         exp_val[cdb_tag], cdb_value));
            end
            seen_cnt[cdb_tag] = seen_cnt[cdb_tag] + 1;
        end
        if (!rst && dispatch_stall === 1'b1) begin
            stall_cnt = stall_cnt + 1;
        end
    end

    initial begin
        op_code_e         rop;
        logic [TAG_W-1:0] rtag;
        bit               rr1;
        bit               rr2;
        logic [XLEN-1:0]  rv1;
        logic [XLEN-1:0]  rv2;
        int               waited;
        int               prev_phase;
        int               stall_mark;
        void'($urandom(7609));
        clk        = 1'b0;
        rst        = 1'b1;
        disp_valid = 1'b0;
        disp_op    = OP_ADD;
        disp_tag   = '0;
        src1_ready = 1'b0;
        src1_tag   = '0;
        src1_value = '0;
        src2_ready = 1'b0;
        src2_tag   = '0;
        src2_value = '0;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (cdb_valid === 1'b0 && dispatch_stall === 1'b0) else begin
            report_failure("cdb_valid or dispatch_stall is not low after reset");
        end

        prev_phase = 0;
        stall_mark = stall_cnt;
        foreach (rows[i]) begin
            if (int'(rows[i].phase) != prev_phase) begin
                finish_phase(prev_phase, stall_mark);
                prev_phase = int'(rows[i].phase);
                stall_mark = stall_cnt;
            end
            dispatch_one(int'(rows[i].phase), rows[i].op, rows[i].tag,
                         rows[i].r1, rows[i].v1, rows[i].r2, rows[i].v2);
        end
        finish_phase(prev_phase, stall_mark);

        // Random ops with dependencies on earlier tags
        stall_mark = stall_cnt;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rop  = op_code_e'(4'($urandom_range(0, 10)));
            rtag = TAG_W'($urandom_range(0, NUM_TAGS - 1));
            waited = 0;
            while (is_pending(rtag)) begin
                tick_or_timeout(waited, "a free tag in the random phase");
                rtag = rtag + 1'b1;
            end
            rr1 = ($urandom_range(0, 1) == 0);
            rr2 = ($urandom_range(0, 1) == 0);
            rv1 = rr1 ? $urandom : XLEN'($urandom_range(0, NUM_TAGS - 1));
            rv2 = rr2 ? $urandom : XLEN'($urandom_range(0, NUM_TAGS - 1));
            dispatch_one(RANDOM_PHASE, rop, rtag, rr1, rv1, rr2, rv2);
            if ($urandom_range(0, 3) == 0) begin
                next_cycle();
            end
        end
        finish_phase(RANDOM_PHASE, stall_mark);

        // Any late broadcast on a quiet bus shows up as a duplicate
        repeat (10) next_cycle();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/issue_pkg.sv
logic/dispatch_decode.sv
logic/reservation_table.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/writeback_bus.sv
logic/issue_core.sv
dv/issue_core_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module issue_core_tb -f project.f

run: build
	./obj_dir/Vissue_core_tb 2>&1 | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module issue_core \
		logic/issue_pkg.sv logic/dispatch_decode.sv logic/reservation_table.sv \
		logic/alu_unit.sv logic/mul_unit.sv logic/writeback_bus.sv logic/issue_core.sv

clean:
	rm -rf obj_dir sim.log
